//--- list.f
+incdir+.
otp_macro_pkg.sv
otp_ctrl_pkg.sv
otp_ctrl_lci.sv
otp_ctrl_dai.sv
otp_arb.sv
otp_macro.sv
otp_ctrl_top.sv
tb_otp_ctrl_top.sv

//--- tb_otp_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "otp_ctrl_settings.svh"

module tb_otp_ctrl_top
  import otp_ctrl_pkg::*;
();

  localparam int DataW = `LC_WORDS * `OTP_WORD_W;
  localparam int AddrW = `OTP_ADDR_W + 1;
  // One burn with a competing DAI access fits well inside this
  localparam int WaitCycles = 2 * `LC_WORDS * (1 + `OTP_RD_LAT) + 16;

  // Partition contents from word 3 down to word 0
  localparam logic [DataW-1:0] LcA = {16'h0101, 16'h00f0, 16'h0f00, 16'h1234};
  // Only sets bits on top of LcA
  localparam logic [DataW-1:0] LcB = {16'h0303, 16'h00f0, 16'h0f0f, 16'h1234};
  // Word 1 drops bit 8 while the other words only set bits
  localparam logic [DataW-1:0] LcC = {16'h0303, 16'h00f3, 16'h0e0f, 16'h123c};

  typedef enum int {OpLc, OpLcDai, OpLcLocked, OpDaiWr, OpDaiRd, OpEsc} op_e;

  logic clk_i = 1'b0;
  logic rst_ni, lci_en_i, esc_en_i, lc_req_i;
  logic [DataW-1:0] lc_data_i;
  logic lc_ack_o, lc_err_o, lci_fsm_err_o, lci_idle_o;
  otp_err_e lci_error_o, dai_err_o;
  logic dai_req_i, dai_write_i, dai_done_o;
  logic [AddrW-1:0] dai_addr_i;
  logic [`OTP_WORD_W-1:0] dai_wdata_i, dai_rdata_o;

  // Stimulus table with one queue per column
  string names[$];
  op_e ops[$];
  int addrs[$];
  logic [DataW-1:0] lc_datas[$];
  logic [`OTP_WORD_W-1:0] wdatas[$];
  otp_err_e exp_errs[$];
  logic table_ready = 1'b0;

  // Expected array contents
  logic [`OTP_WORD_W-1:0] shadow [`OTP_DEPTH];

  integer seed = 17;
  int checks = 0;
  int mismatches = 0;
  int failures = 0;

  always #10 clk_i = ~clk_i;

  otp_ctrl_top u_otp_ctrl_top (
    .clk_i, .rst_ni, .lci_en_i, .esc_en_i, .lc_req_i, .lc_data_i, .lc_ack_o, .lc_err_o,
    .lci_error_o, .lci_fsm_err_o, .lci_idle_o,
    .dai_req_i, .dai_write_i, .dai_addr_i, .dai_wdata_i, .dai_done_o, .dai_rdata_o,
    .dai_err_o
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Bits only go from 0 to 1 and a clearing write leaves the word alone
  task automatic program_word(input int addr, input logic [`OTP_WORD_W-1:0] data);
    if ((addr < `OTP_DEPTH) && ((shadow[addr] & ~data) == '0)) begin
      shadow[addr] = shadow[addr] | data;
    end
  endtask

  function automatic logic [`OTP_WORD_W-1:0] expected_word(input int addr);
    if (addr >= `OTP_DEPTH) begin
      return '0;
    end
    return shadow[addr];
  endfunction

  function automatic logic in_lc_partition(input int addr);
    return (addr >= `LC_OFFSET) && (addr < `LC_OFFSET + `LC_WORDS);
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic compare(input string name, input string what, input logic [63:0] exp,
                         input logic [63:0] got);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("Mismatch %s %s: expected %0h, actual %0h", name, what, exp, got);
    end
  endtask

  task automatic confirm(input string name, input logic ok, input string what);
    checks++;
    assert (ok) else begin
      failures++;
      $display("Error in %s: %s", name, what);
    end
  endtask

  ////////////////////////////////////////
  // Sequences
  ////////////////////////////////////////

  task automatic apply_reset();
    lc_req_i  = 1'b0;
    dai_req_i = 1'b0;
    esc_en_i  = 1'b0;
    lci_en_i  = 1'b0;
    rst_ni    = 1'b0;
    for (int a = 0; a < `OTP_DEPTH; a++) begin
      shadow[a] = '0;
    end
    repeat (2) @(posedge clk_i);
    // Everything quiet while in reset
    confirm("reset", !(lc_ack_o | lc_err_o | lci_fsm_err_o | lci_idle_o | dai_done_o),
            "a pulse or idle output is high during reset");
    compare("reset", "lci_error_o", NoError, lci_error_o);
    compare("reset", "dai_err_o", NoError, dai_err_o);
    #2;
    rst_ni   = 1'b1;
    lci_en_i = 1'b1;
  endtask

  task automatic wait_idle(input string name);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!lci_idle_o && n < WaitCycles);
    confirm(name, lci_idle_o, "life cycle interface never reached idle");
  endtask

  task automatic await_lc_ack(input string name, input otp_err_e exp);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!lc_ack_o && n < WaitCycles);
    confirm(name, lc_ack_o, "no life cycle ack before the timeout");
    // Error pulse rides on the ack
    compare(name, "lc_err_o", 64'(exp != NoError), 64'(lc_err_o));
    @(posedge clk_i);
    #2;
    lc_req_i = 1'b0;
    @(negedge clk_i);
    compare(name, "lci_error_o", 64'(exp), 64'(lci_error_o));
  endtask

  task automatic await_dai_done(input string name, input otp_err_e exp, input logic rd,
                                input int addr);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!dai_done_o && n < WaitCycles);
    confirm(name, dai_done_o, "no DAI done before the timeout");
    compare(name, "dai_err_o", 64'(exp), 64'(dai_err_o));
    if (rd && (exp == NoError)) begin
      compare(name, "dai_rdata_o", 64'(expected_word(addr)), 64'(dai_rdata_o));
    end
  endtask

  task automatic start_dai(input logic wr, input int addr, input logic [15:0] data);
    dai_req_i   = 1'b1;
    dai_write_i = wr;
    dai_addr_i  = AddrW'(addr);
    dai_wdata_i = data;
  endtask

  // Burn the partition and optionally race a DAI write in the same cycle
  task automatic run_lc(input int i);
    wait_idle(names[i]);
    @(posedge clk_i);
    #2;
    lc_data_i = lc_datas[i];
    lc_req_i  = 1'b1;
    if (ops[i] == OpLcDai) begin
      start_dai(1'b1, addrs[i], wdatas[i]);
    end
    @(posedge clk_i);
    #2;
    dai_req_i = 1'b0;
    fork
      await_lc_ack(names[i], exp_errs[i]);
      if (ops[i] == OpLcDai) begin
        await_dai_done(names[i], exp_errs[i], 1'b0, addrs[i]);
      end
    join
    for (int w = 0; w < `LC_WORDS; w++) begin
      program_word(`LC_OFFSET + w, lc_datas[i][w*`OTP_WORD_W +: `OTP_WORD_W]);
    end
    if (ops[i] == OpLcDai) begin
      program_word(addrs[i], wdatas[i]);
    end
  endtask

  task automatic run_locked(input int i);
    logic got_ack, got_idle;
    got_ack  = 1'b0;
    got_idle = 1'b0;
    @(posedge clk_i);
    #2;
    lc_data_i = lc_datas[i];
    lc_req_i  = 1'b1;
    // Nothing may answer within a full burn time
    repeat (WaitCycles) begin
      @(negedge clk_i);
      got_ack  = got_ack | lc_ack_o;
      got_idle = got_idle | lci_idle_o;
    end
    confirm(names[i], !got_ack, "locked life cycle interface acked a request");
    confirm(names[i], !got_idle, "lci_idle_o went high while locked");
    @(posedge clk_i);
    #2;
    lc_req_i = 1'b0;
    compare(names[i], "lci_error_o", 64'(exp_errs[i]), 64'(lci_error_o));
  endtask

  task automatic run_dai(input int i);
    @(posedge clk_i);
    #2;
    start_dai(ops[i] == OpDaiWr, addrs[i], wdatas[i]);
    @(posedge clk_i);
    #2;
    dai_req_i = 1'b0;
    await_dai_done(names[i], exp_errs[i], ops[i] == OpDaiRd, addrs[i]);
    // Partition words are never written through the DAI
    if ((ops[i] == OpDaiWr) && !in_lc_partition(addrs[i])) begin
      program_word(addrs[i], wdatas[i]);
    end
  endtask

  task automatic run_esc(input int i);
    int n;
    n = 0;
    apply_reset();
    wait_idle(names[i]);
    @(posedge clk_i);
    #2;
    esc_en_i = 1'b1;
    do begin
      @(negedge clk_i);
      n++;
    end while (!lci_fsm_err_o && n < WaitCycles);
    confirm(names[i], lci_fsm_err_o, "no FSM error pulse after escalation");
    @(negedge clk_i);
    confirm(names[i], !lci_fsm_err_o, "lci_fsm_err_o stayed high after escalation");
    compare(names[i], "lci_error_o", 64'(exp_errs[i]), 64'(lci_error_o));
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  task automatic add_test(input string name, input op_e op, input int addr,
                          input logic [DataW-1:0] lc_data, input logic [15:0] wdata,
                          input otp_err_e exp);
    names.push_back(name);
    ops.push_back(op);
    addrs.push_back(addr);
    lc_datas.push_back(lc_data);
    wdatas.push_back(wdata);
    exp_errs.push_back(exp);
  endtask

  task automatic load_table();
    logic [31:0] tmp;
    logic [15:0] r0, r1, r2;
    tmp = $random(seed);
    // Nonzero so the clearing write below really clears something
    r0  = (tmp[15:0] | 16'h0001) & ~16'h8000;
    tmp = $random(seed);
    // Top bit is new so the second write really sets more bits
    r1  = tmp[15:0] | 16'h8000;
    tmp = $random(seed);
    // Nonzero so the read back shows the racing write
    r2  = tmp[15:0] | 16'h0010;
    add_test("lc_first", OpLc, 0, LcA, '0, NoError);
    add_test("lc_rd_w0", OpDaiRd, `LC_OFFSET, '0, '0, NoError);
    add_test("lc_rd_w1", OpDaiRd, `LC_OFFSET + 1, '0, '0, NoError);
    add_test("lc_rd_w2", OpDaiRd, `LC_OFFSET + 2, '0, '0, NoError);
    add_test("lc_rd_w3", OpDaiRd, `LC_OFFSET + 3, '0, '0, NoError);
    add_test("dai_wr_set", OpDaiWr, 2, '0, r0, NoError);
    add_test("dai_rd_set", OpDaiRd, 2, '0, '0, NoError);
    add_test("dai_wr_more", OpDaiWr, 2, '0, r0 | r1, NoError);
    add_test("dai_rd_more", OpDaiRd, 2, '0, '0, NoError);
    add_test("dai_wr_clear", OpDaiWr, 2, '0, ~(r0 | r1), WriteBlankError);
    add_test("dai_rd_clear", OpDaiRd, 2, '0, '0, NoError);
    add_test("dai_wr_lc", OpDaiWr, `LC_OFFSET + 1, '0, 16'hffff, AccessError);
    add_test("dai_rd_lc", OpDaiRd, `LC_OFFSET + 1, '0, '0, NoError);
    add_test("dai_rd_range", OpDaiRd, 40, '0, '0, MacroError);
    add_test("lc_dai_same", OpLcDai, 3, LcB, r2, NoError);
    add_test("lc_rd_b_w1", OpDaiRd, `LC_OFFSET + 1, '0, '0, NoError);
    add_test("dai_rd_race", OpDaiRd, 3, '0, '0, NoError);
    add_test("lc_clear", OpLc, 0, LcC, '0, WriteBlankError);
    add_test("lc_rd_c_w0", OpDaiRd, `LC_OFFSET, '0, '0, NoError);
    add_test("lc_rd_c_w1", OpDaiRd, `LC_OFFSET + 1, '0, '0, NoError);
    add_test("lc_rd_c_w2", OpDaiRd, `LC_OFFSET + 2, '0, '0, NoError);
    add_test("lc_locked", OpLcLocked, 0, LcA, '0, WriteBlankError);
    add_test("esc_lock", OpEsc, 0, '0, '0, FsmStateError);
    add_test("esc_no_ack", OpLcLocked, 0, LcA, '0, FsmStateError);
  endtask

  initial begin
    rst_ni      = 1'b0;
    lci_en_i    = 1'b0;
    esc_en_i    = 1'b0;
    lc_req_i    = 1'b0;
    lc_data_i   = '0;
    dai_req_i   = 1'b0;
    dai_write_i = 1'b0;
    dai_addr_i  = '0;
    dai_wdata_i = '0;
    load_table();
    table_ready = 1'b1;
    apply_reset();

    for (int i = 0; i < names.size(); i++) begin
      case (ops[i])
        OpLc, OpLcDai: run_lc(i);
        OpLcLocked:    run_locked(i);
        OpEsc:         run_esc(i);
        default:       run_dai(i);
      endcase
    end

    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches,
             failures);
    if (mismatches + failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Hard stop scaled by the table length
  initial begin
    wait (table_ready);
    repeat (names.size() * 50) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, run did not finish", names.size() * 50);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- otp_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "otp_ctrl_settings.svh"

module otp_ctrl_top
  import otp_macro_pkg::*;
  import otp_ctrl_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Life cycle port
  input  logic                             lci_en_i,
  input  logic                             esc_en_i,
  input  logic                             lc_req_i,
  input  logic [`LC_WORDS*`OTP_WORD_W-1:0] lc_data_i,
  output logic                             lc_ack_o,
  output logic                             lc_err_o,
  output otp_err_e                         lci_error_o,
  output logic                             lci_fsm_err_o,
  output logic                             lci_idle_o,
  // Direct access port
  input  logic                             dai_req_i,
  input  logic                             dai_write_i,
  input  logic [`OTP_ADDR_W:0]             dai_addr_i,
  input  logic [`OTP_WORD_W-1:0]           dai_wdata_i,
  output logic                             dai_done_o,
  output logic [`OTP_WORD_W-1:0]           dai_rdata_o,
  output otp_err_e                         dai_err_o
);

  // LCI to arbiter
  logic lci_req, lci_gnt, lci_rvalid;
  otp_cmd_e lci_cmd;
  logic [`OTP_ADDR_W:0] lci_addr;
  logic [`OTP_WORD_W-1:0] lci_wdata;
  otp_macro_err_e lci_merr;

  // DAI to arbiter
  logic dai_req, dai_gnt, dai_rvalid;
  otp_cmd_e dai_cmd;
  logic [`OTP_ADDR_W:0] dai_addr;
  logic [`OTP_WORD_W-1:0] dai_wdata, arb_rdata;
  otp_macro_err_e dai_merr;

  // Arbiter to macro
  logic m_req, m_gnt, m_rvalid;
  otp_cmd_e m_cmd;
  logic [`OTP_ADDR_W:0] m_addr;
  logic [`OTP_WORD_W-1:0] m_wdata, m_rdata;
  otp_macro_err_e m_err;

  otp_ctrl_lci u_lci (
    .clk_i, .rst_ni, .lci_en_i, .esc_en_i, .lc_req_i, .lc_data_i, .lc_ack_o, .lc_err_o,
    .error_o(lci_error_o), .fsm_err_o(lci_fsm_err_o), .lci_idle_o,
    .otp_req_o(lci_req), .otp_cmd_o(lci_cmd), .otp_addr_o(lci_addr),
    .otp_wdata_o(lci_wdata), .otp_gnt_i(lci_gnt), .otp_rvalid_i(lci_rvalid),
    .otp_err_i(lci_merr)
  );

  otp_ctrl_dai u_dai (
    .clk_i, .rst_ni, .dai_req_i, .dai_write_i, .dai_addr_i, .dai_wdata_i,
    .dai_done_o, .dai_rdata_o, .dai_err_o,
    .otp_req_o(dai_req), .otp_cmd_o(dai_cmd), .otp_addr_o(dai_addr),
    .otp_wdata_o(dai_wdata), .otp_gnt_i(dai_gnt), .otp_rvalid_i(dai_rvalid),
    .otp_rdata_i(arb_rdata), .otp_err_i(dai_merr)
  );

  // Life cycle interface is client 0
  otp_arb u_arb (
    .clk_i, .rst_ni,
    .c0_req_i(lci_req), .c0_cmd_i(lci_cmd), .c0_addr_i(lci_addr), .c0_wdata_i(lci_wdata),
    .c0_gnt_o(lci_gnt), .c0_rvalid_o(lci_rvalid), .c0_err_o(lci_merr),
    .c1_req_i(dai_req), .c1_cmd_i(dai_cmd), .c1_addr_i(dai_addr), .c1_wdata_i(dai_wdata),
    .c1_gnt_o(dai_gnt), .c1_rvalid_o(dai_rvalid), .c1_err_o(dai_merr),
    .rdata_o(arb_rdata),
    .mreq_o(m_req), .mcmd_o(m_cmd), .maddr_o(m_addr), .mwdata_o(m_wdata),
    .mgnt_i(m_gnt), .mrvalid_i(m_rvalid), .mrdata_i(m_rdata), .merr_i(m_err)
  );

  otp_macro u_macro (
    .clk_i, .rst_ni,
    .req_i(m_req), .cmd_i(m_cmd), .addr_i(m_addr), .wdata_i(m_wdata),
    .gnt_o(m_gnt), .rvalid_o(m_rvalid), .rdata_o(m_rdata), .err_o(m_err)
  );

endmodule

`default_nettype wire

//--- otp_macro.sv
`timescale 1ns/1ps
`default_nettype none

`include "otp_ctrl_settings.svh"

module otp_macro
  import otp_macro_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  otp_cmd_e               cmd_i,
  input  logic [`OTP_ADDR_W:0]   addr_i,
  input  logic [`OTP_WORD_W-1:0] wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic [`OTP_WORD_W-1:0] rdata_o,
  output otp_macro_err_e         err_o
);

  localparam int CntW = $clog2(`OTP_RD_LAT + 1);

  logic [`OTP_WORD_W-1:0] mem_q [`OTP_DEPTH];
  logic busy_q;
  logic [CntW-1:0] cnt_q;
  otp_macro_err_e err_d, err_q;
  otp_cmd_e cmd_q;
  logic [`OTP_ADDR_W-1:0] addr_q;
  logic [`OTP_WORD_W-1:0] wdata_q, rdata_q, cur_word;

  // One transaction at a time
  assign gnt_o    = req_i && !busy_q;
  assign rvalid_o = busy_q && (cnt_q == '0);
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

  assign cur_word = mem_q[addr_i[`OTP_ADDR_W-1:0]];

  // Range and blank check at grant
  always_comb begin
    err_d = MacroOk;
    if (int'(addr_i) >= `OTP_DEPTH) begin
      err_d = MacroAddrErr;
    end else if ((cmd_i == Write) && ((cur_word & ~wdata_i) != '0)) begin
      // Would clear a programmed bit
      err_d = MacroWriteBlankErr;
    end
  end

  ////////////////////////////////////////
  // Latency counter
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      err_q  <= MacroOk;
    end else if (gnt_o) begin
      busy_q <= 1'b1;
      cnt_q  <= CntW'(`OTP_RD_LAT - 1);
      err_q  <= err_d;
    end else if (rvalid_o) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      cmd_q   <= cmd_i;
      addr_q  <= addr_i[`OTP_ADDR_W-1:0];
      wdata_q <= wdata_i;
      rdata_q <= (err_d == MacroAddrErr) ? '0 : cur_word;
    end
  end

  // Array starts blank, bits only ever go from 0 to 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `OTP_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (rvalid_o && (cmd_q == Write) && (err_q == MacroOk)) begin
      mem_q[addr_q] <= mem_q[addr_q] | wdata_q;
    end
  end

  a_fixed_lat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_o |-> ##`OTP_RD_LAT rvalid_o);

  // Requests arriving while busy are held off until the response
  a_gnt_withheld: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_o |=> !gnt_o [*`OTP_RD_LAT]);

endmodule

`default_nettype wire

//--- otp_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "otp_ctrl_settings.svh"

module otp_arb
  import otp_macro_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Client 0
  input  logic                   c0_req_i,
  input  otp_cmd_e               c0_cmd_i,
  input  logic [`OTP_ADDR_W:0]   c0_addr_i,
  input  logic [`OTP_WORD_W-1:0] c0_wdata_i,
  output logic                   c0_gnt_o,
  output logic                   c0_rvalid_o,
  output otp_macro_err_e         c0_err_o,
  // Client 1
  input  logic                   c1_req_i,
  input  otp_cmd_e               c1_cmd_i,
  input  logic [`OTP_ADDR_W:0]   c1_addr_i,
  input  logic [`OTP_WORD_W-1:0] c1_wdata_i,
  output logic                   c1_gnt_o,
  output logic                   c1_rvalid_o,
  output otp_macro_err_e         c1_err_o,
  output logic [`OTP_WORD_W-1:0] rdata_o,
  // Macro side
  output logic                   mreq_o,
  output otp_cmd_e               mcmd_o,
  output logic [`OTP_ADDR_W:0]   maddr_o,
  output logic [`OTP_WORD_W-1:0] mwdata_o,
  input  logic                   mgnt_i,
  input  logic                   mrvalid_i,
  input  logic [`OTP_WORD_W-1:0] mrdata_i,
  input  otp_macro_err_e         merr_i
);

  // High selects client 1
  logic sel;
  // Client granted last, doubles as owner of the transaction in flight
  logic last_q;

  // On contention the client not served last wins
  assign sel = c1_req_i && (!c0_req_i || !last_q);

  // Forward the winner in the same cycle
  assign mreq_o   = c0_req_i || c1_req_i;
  assign mcmd_o   = sel ? c1_cmd_i : c0_cmd_i;
  assign maddr_o  = sel ? c1_addr_i : c0_addr_i;
  assign mwdata_o = sel ? c1_wdata_i : c0_wdata_i;

  assign c0_gnt_o = mgnt_i && !sel;
  assign c1_gnt_o = mgnt_i && sel;

  // Response goes back to the owner only
  assign c0_rvalid_o = mrvalid_i && !last_q;
  assign c1_rvalid_o = mrvalid_i && last_q;
  assign c0_err_o    = last_q ? MacroOk : merr_i;
  assign c1_err_o    = last_q ? merr_i : MacroOk;
  assign rdata_o     = mrdata_i;

  // Reset value gives client 0 the first turn
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= 1'b1;
    end else if (mgnt_i) begin
      last_q <= sel;
    end
  end

  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(c0_gnt_o && c1_gnt_o));

  // Client 0 gets its response before client 1 sees any
  a_c0_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    c0_gnt_o |=> (!c1_rvalid_o until c0_rvalid_o));

endmodule

`default_nettype wire

//--- otp_ctrl_dai.sv
`timescale 1ns/1ps
`default_nettype none

`include "otp_ctrl_settings.svh"

module otp_ctrl_dai
  import otp_macro_pkg::*;
  import otp_ctrl_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Single word command
  input  logic                   dai_req_i,
  input  logic                   dai_write_i,
  input  logic [`OTP_ADDR_W:0]   dai_addr_i,
  input  logic [`OTP_WORD_W-1:0] dai_wdata_i,
  output logic                   dai_done_o,
  output logic [`OTP_WORD_W-1:0] dai_rdata_o,
  output otp_err_e               dai_err_o,
  // Macro side
  output logic                   otp_req_o,
  output otp_cmd_e               otp_cmd_o,
  output logic [`OTP_ADDR_W:0]   otp_addr_o,
  output logic [`OTP_WORD_W-1:0] otp_wdata_o,
  input  logic                   otp_gnt_i,
  input  logic                   otp_rvalid_i,
  input  logic [`OTP_WORD_W-1:0] otp_rdata_i,
  input  otp_macro_err_e         otp_err_i
);

  typedef enum logic [1:0] {
    DaiIdle,
    DaiReq,
    DaiWait
  } dai_state_e;

  dai_state_e state_q;
  logic done_q;
  otp_err_e err_q;
  logic write_q;
  logic [`OTP_ADDR_W:0] addr_q;
  logic [`OTP_WORD_W-1:0] wdata_q, rdata_q;
  logic accept, lc_hit, refuse;

  // New commands are taken only in Idle
  assign accept = (state_q == DaiIdle) && dai_req_i;
  assign lc_hit = (dai_addr_i >= `LC_OFFSET) && (dai_addr_i < `LC_OFFSET + `LC_WORDS);
  // Life cycle words are only burned through the LCI
  assign refuse = dai_write_i && lc_hit;

  assign otp_req_o   = (state_q == DaiReq);
  assign otp_cmd_o   = write_q ? Write : Read;
  assign otp_addr_o  = addr_q;
  assign otp_wdata_o = wdata_q;

  assign dai_done_o  = done_q;
  assign dai_rdata_o = rdata_q;
  assign dai_err_o   = err_q;

  ////////////////////////////////////////
  // Command sequencing
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DaiIdle;
      done_q  <= 1'b0;
      err_q   <= NoError;
    end else begin
      done_q <= 1'b0;
      unique case (state_q)
        DaiIdle: begin
          if (accept && refuse) begin
            // Finish right away without a macro access
            done_q <= 1'b1;
            err_q  <= AccessError;
          end else if (accept) begin
            state_q <= DaiReq;
          end
        end
        DaiReq: begin
          if (otp_gnt_i) begin
            state_q <= DaiWait;
          end
        end
        DaiWait: begin
          if (otp_rvalid_i) begin
            done_q  <= 1'b1;
            err_q   <= to_otp_err(otp_err_i);
            state_q <= DaiIdle;
          end
        end
        default: begin
          state_q <= DaiIdle;
        end
      endcase
    end
  end

  // Captured command and returned data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      write_q <= dai_write_i;
      addr_q  <= dai_addr_i;
      wdata_q <= dai_wdata_i;
    end
    if ((state_q == DaiWait) && otp_rvalid_i) begin
      rdata_q <= otp_rdata_i;
    end
  end

  // A refused write never turns into a macro request
  a_no_req_refused: assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_req_o |-> !(write_q && (addr_q >= `LC_OFFSET)
                    && (addr_q < `LC_OFFSET + `LC_WORDS)));

endmodule

`default_nettype wire

//--- otp_ctrl_lci.sv
`timescale 1ns/1ps
`default_nettype none

`include "otp_ctrl_settings.svh"

module otp_ctrl_lci
  import otp_macro_pkg::*;
  import otp_ctrl_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             lci_en_i,
  // Escalation level that locks the FSM in its terminal state
  input  logic                             esc_en_i,
  // Transition request and the new partition contents
  input  logic                             lc_req_i,
  input  logic [`LC_WORDS*`OTP_WORD_W-1:0] lc_data_i,
  output logic                             lc_ack_o,
  output logic                             lc_err_o,
  output otp_err_e                         error_o,
  output logic                             fsm_err_o,
  output logic                             lci_idle_o,
  // Macro side
  output logic                             otp_req_o,
  output otp_cmd_e                         otp_cmd_o,
  output logic [`OTP_ADDR_W:0]             otp_addr_o,
  output logic [`OTP_WORD_W-1:0]           otp_wdata_o,
  input  logic                             otp_gnt_i,
  input  logic                             otp_rvalid_i,
  input  otp_macro_err_e                   otp_err_i
);

  localparam int AddrW = `OTP_ADDR_W + 1;
  localparam int CntW = $clog2(`LC_WORDS);
  localparam logic [CntW-1:0] LastWord = CntW'(`LC_WORDS - 1);

  lci_state_e state_d, state_q;
  otp_err_e error_d, error_q;
  logic [CntW-1:0] cnt_q;
  logic cnt_clr, cnt_en;

  assign error_o = error_q;
  // Only Idle accepts a new transition
  assign lci_idle_o = (state_q == IdleSt);

  ////////////////////////////////////////
  // Burn sequence
  ////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    error_d   = error_q;
    cnt_clr   = 1'b0;
    cnt_en    = 1'b0;
    otp_req_o = 1'b0;
    otp_cmd_o = Read;
    lc_ack_o  = 1'b0;
    lc_err_o  = 1'b0;
    fsm_err_o = 1'b0;

    unique case (state_q)
      // Wait for the enable after reset
      ResetSt: begin
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      IdleSt: begin
        if (lc_req_i) begin
          state_d = WriteSt;
          cnt_clr = 1'b1;
        end
      end
      // Hold the write request until the arbiter takes it
      WriteSt: begin
        otp_req_o = 1'b1;
        otp_cmd_o = Write;
        if (otp_gnt_i) begin
          state_d = WriteWaitSt;
        end
      end
      WriteWaitSt: begin
        if (otp_rvalid_i) begin
          // Keep going on errors and remember the code
          if (otp_err_i != MacroOk) begin
            error_d = to_otp_err(otp_err_i);
          end
          if (cnt_q == LastWord) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            cnt_en  = 1'b1;
            state_d = WriteSt;
          end
        end
      end
      // Terminal state that nothing leaves
      ErrorSt: begin
      end
      // Glitched into an unused encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
    endcase

    // Escalation overrides everything
    if (esc_en_i) begin
      state_d = ErrorSt;
      fsm_err_o = (state_q != ErrorSt);
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  // Partition word address and the matching slice of the new state
  assign otp_addr_o  = AddrW'(`LC_OFFSET) + AddrW'(cnt_q);
  assign otp_wdata_o = otp_req_o ? lc_data_i[cnt_q*`OTP_WORD_W +: `OTP_WORD_W] : '0;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (cnt_en) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // A pending burn keeps its command and address until granted
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_req_o && !otp_gnt_i && !esc_en_i
      |=> otp_req_o && otp_cmd_o == Write && $stable(otp_addr_o));

  // The ack closes the burn with no request in that cycle or the next
  a_ack_ends: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lc_ack_o |-> !otp_req_o ##1 !otp_req_o);

endmodule

`default_nettype wire

//--- otp_ctrl_pkg.sv
`default_nettype none

package otp_ctrl_pkg;

  import otp_macro_pkg::*;

  // Controller level error code
  typedef enum logic [2:0] {
    NoError         = 3'd0,
    MacroError      = 3'd1,
    WriteBlankError = 3'd2,
    AccessError     = 3'd3,
    FsmStateError   = 3'd4
  } otp_err_e;

  ////////////////////////////////////////
  // Life cycle interface FSM
  ////////////////////////////////////////

  // Sparse encoding, minimum Hamming distance 5
  typedef enum logic [8:0] {
    ResetSt     = 9'b000101011,
    IdleSt      = 9'b110011110,
    WriteSt     = 9'b101010001,
    WriteWaitSt = 9'b010000000,
    ErrorSt     = 9'b011111101
  } lci_state_e;

  // Map a macro response onto the controller error code
  function automatic otp_err_e to_otp_err(otp_macro_err_e err);
    case (err)
      MacroOk:            return NoError;
      MacroWriteBlankErr: return WriteBlankError;
      default:            return MacroError;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- otp_macro_pkg.sv
`default_nettype none

package otp_macro_pkg;

  ////////////////////////////////////////
  // Macro command and response
  ////////////////////////////////////////

  // Command issued with a macro request
  typedef enum logic {
    Read  = 1'b0,
    Write = 1'b1
  } otp_cmd_e;

  // Response code returned with rvalid
  typedef enum logic [1:0] {
    // Access completed
    MacroOk            = 2'd0,
    // Write would clear an already programmed bit
    MacroWriteBlankErr = 2'd1,
    // Address beyond the array
    MacroAddrErr       = 2'd2
  } otp_macro_err_e;

endpackage

`default_nettype wire

//--- otp_ctrl_settings.svh
`ifndef OTP_CTRL_SETTINGS_SVH
`define OTP_CTRL_SETTINGS_SVH

////////////////////////////////////////
// Macro geometry
////////////////////////////////////////

// Native OTP word width in bits
`define OTP_WORD_W 16

// Number of native words in the macro
`define OTP_DEPTH 32

// Word address width of the array
// Client and macro address ports carry one more bit for out of range requests
`define OTP_ADDR_W 5

////////////////////////////////////////
// Life cycle partition and timing
////////////////////////////////////////

// First word of the life cycle partition
`define LC_OFFSET 8

// Words in the life cycle partition
`define LC_WORDS 4

// Cycles from grant to response valid
`define OTP_RD_LAT 2

`endif
